// File: all.f
design/cache_pkg.sv
design/mem_msg_pkg.sv
design/cache_tag_state.sv
design/cache_data_array.sv
design/cache_ctrl.sv
design/blocking_cache.sv
verif/tb_clock_gen.sv
verif/cache_checker.sv
verif/blocking_cache_tb.sv

// File: design/blocking_cache.sv
// ----------------------------------------------------------
// Two-way write-back blocking L1 data cache, top level
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module blocking_cache #(
  parameter int num_sets = cache_pkg::default_num_sets
) (
  input  logic                   clk,
  input  logic                   reset,
  // Processor request
  input  logic                   cachereq_val,
  input  mem_msg_pkg::req_type_t cachereq_type,
  input  cache_pkg::addr_t       cachereq_addr,
  input  cache_pkg::word_t       cachereq_data,
  output logic                   cachereq_rdy,
  // Processor response
  output logic                   cacheresp_val,
  output mem_msg_pkg::req_type_t cacheresp_type,
  output cache_pkg::word_t       cacheresp_data,
  input  logic                   cacheresp_rdy,
  // Memory request
  output logic                   memreq_val,
  output mem_msg_pkg::req_type_t memreq_type,
  output mem_msg_pkg::mem_addr_t memreq_addr,
  output cache_pkg::line_t       memreq_data,
  input  logic                   memreq_rdy,
  // Memory response
  input  logic                   memresp_val,
  input  cache_pkg::line_t       memresp_data,
  output logic                   memresp_rdy
);
  import cache_pkg::*;

  localparam int tag_bits = addr_bits - offset_bits - $clog2(num_sets);

  addr_t               req_addr;
  word_t               req_data;
  logic                hit;
  logic                way_sel;
  logic                victim_dirty;
  logic [tag_bits-1:0] victim_tag;
  logic                tag_check;
  logic                record_way;
  logic                tag_write;
  logic                set_dirty;
  logic                clear_dirty;
  logic                touch_lru;
  logic                word_write;
  logic                line_fill;
  logic                line_read;

  cache_ctrl #(
    .num_sets (num_sets)
  ) i_ctrl (
    .clk            (clk),
    .reset          (reset),
    .cachereq_val   (cachereq_val),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .cachereq_rdy   (cachereq_rdy),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_type (cacheresp_type),
    .cacheresp_rdy  (cacheresp_rdy),
    .memreq_val     (memreq_val),
    .memreq_type    (memreq_type),
    .memreq_addr    (memreq_addr),
    .memreq_rdy     (memreq_rdy),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .victim_tag     (victim_tag),
    .tag_check      (tag_check),
    .record_way     (record_way),
    .tag_write      (tag_write),
    .set_dirty      (set_dirty),
    .clear_dirty    (clear_dirty),
    .touch_lru      (touch_lru),
    .req_addr       (req_addr),
    .req_data       (req_data),
    .word_write     (word_write),
    .line_fill      (line_fill),
    .line_read      (line_read)
  );

  cache_tag_state #(
    .num_sets (num_sets)
  ) i_tag_state (
    .clk          (clk),
    .reset        (reset),
    .req_addr     (req_addr),
    .tag_check    (tag_check),
    .record_way   (record_way),
    .tag_write    (tag_write),
    .set_dirty    (set_dirty),
    .clear_dirty  (clear_dirty),
    .touch_lru    (touch_lru),
    .hit          (hit),
    .way_sel      (way_sel),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  // Victim line feeds the writeback, the word feeds responses
  cache_data_array #(
    .num_sets (num_sets)
  ) i_data_array (
    .clk          (clk),
    .req_addr     (req_addr),
    .way_sel      (way_sel),
    .req_data     (req_data),
    .memresp_data (memresp_data),
    .word_write   (word_write),
    .line_fill    (line_fill),
    .line_read    (line_read),
    .read_word    (cacheresp_data),
    .victim_line  (memreq_data)
  );

endmodule

`default_nettype wire

// File: design/cache_ctrl.sv
// ----------------------------------------------------------
// Blocking cache controller: one request at a time through
// tag check, data access, evict, refill and response
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
  parameter int  num_sets = cache_pkg::default_num_sets,
  localparam int idx_bits = $clog2(num_sets),
  localparam int tag_bits = cache_pkg::addr_bits - cache_pkg::offset_bits - idx_bits
) (
  input  logic                  clk,
  input  logic                  reset,
  // Processor side
  input  logic                  cachereq_val,
  input  mem_msg_pkg::req_type_t cachereq_type,
  input  cache_pkg::addr_t      cachereq_addr,
  input  cache_pkg::word_t      cachereq_data,
  output logic                  cachereq_rdy,
  output logic                  cacheresp_val,
  output mem_msg_pkg::req_type_t cacheresp_type,
  input  logic                  cacheresp_rdy,
  // Memory side
  output logic                  memreq_val,
  output mem_msg_pkg::req_type_t memreq_type,
  output mem_msg_pkg::mem_addr_t memreq_addr,
  input  logic                  memreq_rdy,
  input  logic                  memresp_val,
  output logic                  memresp_rdy,
  // Tag state
  input  logic                  hit,
  input  logic                  victim_dirty,
  input  logic [tag_bits-1:0]   victim_tag,
  output logic                  tag_check,
  output logic                  record_way,
  output logic                  tag_write,
  output logic                  set_dirty,
  output logic                  clear_dirty,
  output logic                  touch_lru,
  // Data array
  output cache_pkg::addr_t      req_addr,
  output cache_pkg::word_t      req_data,
  output logic                  word_write,
  output logic                  line_fill,
  output logic                  line_read
);
  import cache_pkg::*;
  import mem_msg_pkg::*;

  // ----------------------------------------------------------
  // States
  // ----------------------------------------------------------
  localparam logic [3:0] st_idle        = 4'd0;
  localparam logic [3:0] st_tag_check   = 4'd1;
  localparam logic [3:0] st_read_acc    = 4'd2;
  localparam logic [3:0] st_write_acc   = 4'd3;
  localparam logic [3:0] st_wait        = 4'd4;
  localparam logic [3:0] st_refill_req  = 4'd5;
  localparam logic [3:0] st_refill_wait = 4'd6;
  localparam logic [3:0] st_refill_upd  = 4'd7;
  localparam logic [3:0] st_evict_prep  = 4'd8;
  localparam logic [3:0] st_evict_req   = 4'd9;
  localparam logic [3:0] st_evict_wait  = 4'd10;

  logic [3:0] state_q;
  logic [3:0] state_d;
  req_type_t  req_type_q;
  logic       req_go;
  logic       resp_go;
  logic       memreq_go;
  logic       memresp_go;
  logic       is_write;
  logic [11:0] cs;

  assign req_go     = cachereq_val && cachereq_rdy;
  assign resp_go    = cacheresp_val && cacheresp_rdy;
  assign memreq_go  = memreq_val && memreq_rdy;
  assign memresp_go = memresp_val && memresp_rdy;
  assign is_write   = (req_type_q == req_write);

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Accepted request, held for the whole transaction
  always_ff @(posedge clk) begin
    if (req_go) begin
      req_type_q <= cachereq_type;
      req_addr   <= cachereq_addr;
      req_data   <= cachereq_data;
    end
  end

  // ----------------------------------------------------------
  // Next state
  // ----------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (req_go) state_d = st_tag_check;
      end
      st_tag_check: begin
        if (hit) begin
          state_d = is_write ? st_write_acc : st_read_acc;
        end else if (victim_dirty) begin
          state_d = st_evict_prep;
        end else begin
          state_d = st_refill_req;
        end
      end
      st_read_acc,
      st_write_acc:   state_d = st_wait;
      st_wait: begin
        if (resp_go) state_d = st_idle;
      end
      st_refill_req: begin
        if (memreq_go) state_d = st_refill_wait;
      end
      st_refill_wait: begin
        if (memresp_go) state_d = st_refill_upd;
      end
      st_refill_upd:  state_d = is_write ? st_write_acc : st_read_acc;
      st_evict_prep:  state_d = st_evict_req;
      st_evict_req: begin
        if (memreq_go) state_d = st_evict_wait;
      end
      st_evict_wait: begin
        if (memresp_go) state_d = st_refill_req;
      end
      default:        state_d = st_idle;
    endcase
  end

  // ----------------------------------------------------------
  // Control table
  // ----------------------------------------------------------
  // Columns: cachereq_rdy cacheresp_val memreq_val memresp_rdy
  //   tag_check record_way tag_write set_dirty clear_dirty
  //   touch_lru word_write line_read
  always_comb begin
    case (state_q)
      st_idle:        cs = 12'b1000_0000_0000;
      st_tag_check:   cs = 12'b0000_1100_0000;
      st_read_acc:    cs = 12'b0000_0000_0101;
      st_write_acc:   cs = 12'b0000_0001_0110;
      st_wait:        cs = 12'b0100_0000_0000;
      st_refill_req:  cs = 12'b0010_0000_0000;
      st_refill_wait: cs = 12'b0001_0000_0000;
      st_refill_upd:  cs = 12'b0000_0010_1000;
      st_evict_prep:  cs = 12'b0000_0000_0001;
      st_evict_req:   cs = 12'b0010_0000_0000;
      st_evict_wait:  cs = 12'b0001_0000_0000;
      default:        cs = 12'b0000_0000_0000;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy,
          tag_check, record_way, tag_write, set_dirty, clear_dirty,
          touch_lru, word_write, line_read} = cs;

  // Refill data lands at the response edge itself
  assign line_fill = (state_q == st_refill_wait) && memresp_val;

  assign cacheresp_type = req_type_q;

  // Writeback goes to the victim's line, refill to the request's
  assign memreq_type = (state_q == st_evict_req) ? req_write : req_read;
  assign memreq_addr = (state_q == st_evict_req)
                     ? {victim_tag, req_addr[offset_bits +: idx_bits], {offset_bits{1'b0}}}
                     : {req_addr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};

  // ----------------------------------------------------------
  // Handshake rules
  // ----------------------------------------------------------
  a_memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=>
      memreq_val && $stable(memreq_addr) && $stable(memreq_type));

  a_cacheresp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_type));

endmodule

`default_nettype wire

// File: design/cache_data_array.sv
// ----------------------------------------------------------
// Line storage for both ways: word writes, line refill,
// registered word and victim line reads
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_data_array #(
  parameter int num_sets = cache_pkg::default_num_sets
) (
  input  logic             clk,
  input  cache_pkg::addr_t req_addr,
  input  logic             way_sel,
  input  cache_pkg::word_t req_data,
  input  cache_pkg::line_t memresp_data,
  input  logic             word_write,
  input  logic             line_fill,
  input  logic             line_read,
  output cache_pkg::word_t read_word,
  output cache_pkg::line_t victim_line
);
  import cache_pkg::*;

  localparam int idx_bits = $clog2(num_sets);

  line_t data_mem [num_ways][num_sets];

  logic [idx_bits-1:0]      idx;
  logic [word_sel_bits-1:0] word_sel;

  assign idx      = req_addr[offset_bits +: idx_bits];
  assign word_sel = req_addr[offset_bits-1 -: word_sel_bits];

  // Refill replaces the whole line, a store touches one word
  always_ff @(posedge clk) begin
    if (line_fill) begin
      data_mem[way_sel][idx] <= memresp_data;
    end else if (word_write) begin
      data_mem[way_sel][idx][word_sel*word_bits +: word_bits] <= req_data;
    end
  end

  // Registered read, valid the cycle after line_read
  always_ff @(posedge clk) begin
    if (line_read) begin
      victim_line <= data_mem[way_sel][idx];
      read_word   <= data_mem[way_sel][idx][word_sel*word_bits +: word_bits];
    end
  end

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
// ----------------------------------------------------------
// Cache geometry: line and word sizes, ways and the
// address widths derived from them
// ----------------------------------------------------------
`default_nettype none

package cache_pkg;

  // ----------------------------------------------------------
  // Base geometry
  // ----------------------------------------------------------
  localparam int addr_bits        = 32;
  localparam int word_bits        = 32;
  localparam int words_per_line   = 4;
  localparam int num_ways         = 2;
  localparam int default_num_sets = 8;

  // ----------------------------------------------------------
  // Derived widths
  // ----------------------------------------------------------
  localparam int line_bits     = words_per_line * word_bits;
  // Byte offset within one line
  localparam int offset_bits   = $clog2(line_bits / 8);
  // Word index within one line, sits at the top of the offset
  localparam int word_sel_bits = $clog2(words_per_line);

  typedef logic [line_bits-1:0] line_t;
  typedef logic [word_bits-1:0] word_t;
  typedef logic [addr_bits-1:0] addr_t;

endpackage

`default_nettype wire

// File: design/cache_tag_state.sv
// ----------------------------------------------------------
// Tag, valid, dirty and LRU state for a two-way cache,
// with hit detection and way selection
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_tag_state #(
  parameter int  num_sets = cache_pkg::default_num_sets,
  localparam int idx_bits = $clog2(num_sets),
  localparam int tag_bits = cache_pkg::addr_bits - cache_pkg::offset_bits - idx_bits
) (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::addr_t    req_addr,
  input  logic                tag_check,
  input  logic                record_way,
  input  logic                tag_write,
  input  logic                set_dirty,
  input  logic                clear_dirty,
  input  logic                touch_lru,
  output logic                hit,
  output logic                way_sel,
  output logic                victim_dirty,
  output logic [tag_bits-1:0] victim_tag
);
  import cache_pkg::*;

  logic [idx_bits-1:0] idx;
  logic [tag_bits-1:0] tag;

  // ----------------------------------------------------------
  // State arrays
  // ----------------------------------------------------------
  logic [tag_bits-1:0] tag_mem [num_ways][num_sets];
  logic [num_ways-1:0][num_sets-1:0] valid;
  logic [num_ways-1:0][num_sets-1:0] dirty;
  // Per set, the way to replace next
  logic [num_sets-1:0] lru;

  logic [num_ways-1:0] way_hit;
  logic                lru_way;
  logic                way_next;

  assign idx = req_addr[offset_bits +: idx_bits];
  assign tag = req_addr[addr_bits-1 -: tag_bits];

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      way_hit[w] = valid[w][idx] && (tag_mem[w][idx] == tag);
    end
  end

  assign hit     = tag_check && (|way_hit);
  assign lru_way = lru[idx];

  // Hit way on a hit, otherwise the LRU way gets the refill
  assign way_next = hit ? way_hit[1] : lru_way;

  // Victim info holds until the refill rewrites the tag
  assign victim_dirty = valid[lru_way][idx] && dirty[lru_way][idx];
  assign victim_tag   = tag_mem[lru_way][idx];

  // ----------------------------------------------------------
  // Control state updates
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid   <= '0;
      dirty   <= '0;
      lru     <= '0;
      way_sel <= 1'b0;
    end else begin
      if (record_way) begin
        way_sel <= way_next;
      end
      if (tag_write) begin
        valid[way_sel][idx] <= 1'b1;
      end
      if (set_dirty) begin
        dirty[way_sel][idx] <= 1'b1;
      end else if (clear_dirty) begin
        dirty[way_sel][idx] <= 1'b0;
      end
      // Other way becomes the replacement choice
      if (touch_lru) begin
        lru[idx] <= ~way_sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tag_write) begin
      tag_mem[way_sel][idx] <= tag;
    end
  end

  // Refill must never leave two copies of a line in one set
  a_single_hit: assert property (@(posedge clk) disable iff (reset)
    tag_check |-> $onehot0(way_hit));

endmodule

`default_nettype wire

// File: design/mem_msg_pkg.sv
// ----------------------------------------------------------
// Message fields shared by the processor and memory ports
// ----------------------------------------------------------
`default_nettype none

package mem_msg_pkg;

  localparam int req_type_bits = 1;
  localparam int mem_addr_bits = 32;

  typedef logic [req_type_bits-1:0] req_type_t;

  // Request type codes, same on both ports
  localparam req_type_t req_read  = 1'b0;
  localparam req_type_t req_write = 1'b1;

  // Memory side always moves whole aligned lines
  typedef logic [mem_addr_bits-1:0] mem_addr_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the blocking cache testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module blocking_cache_tb -Mdir "$build_dir" -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vblocking_cache_tb" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$log_file"; then
  exit 0
fi
echo "Pass line not found in $log_file"
exit 1

// File: verif/blocking_cache_tb.sv
// ----------------------------------------------------------
// Blocking cache testbench: directed and random requests,
// line memory model with random latency, run limit
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module blocking_cache_tb;
  import cache_pkg::*;
  import mem_msg_pkg::*;

  localparam int num_sets       = 8;
  localparam int directed_reqs  = 9;
  localparam int bp_reqs        = 60;
  localparam int random_reqs    = 300;
  localparam int timeout_cycles = 40 * (directed_reqs + bp_reqs + random_reqs) + 200;

  logic      clk;
  logic      reset;
  logic      cachereq_val;
  req_type_t cachereq_type;
  addr_t     cachereq_addr;
  word_t     cachereq_data;
  logic      cachereq_rdy;
  logic      cacheresp_val;
  req_type_t cacheresp_type;
  word_t     cacheresp_data;
  logic      cacheresp_rdy;
  logic      memreq_val;
  req_type_t memreq_type;
  mem_addr_t memreq_addr;
  line_t     memreq_data;
  logic      memreq_rdy;
  logic      memresp_val;
  line_t     memresp_data;
  logic      memresp_rdy;

  int          compare_errors;
  int          protocol_errors;
  int          resp_count;
  int          directed_errors = 0;
  int          issued = 0;
  int          cycle_count = 0;
  int          mem_reads = 0;
  int          mem_writes = 0;
  addr_t       last_read_addr;
  addr_t       last_write_addr;
  line_t       last_write_line;
  logic        backpressure = 1'b0;
  logic [31:0] stim_state;
  line_t       mem_lines [addr_t];

  tb_clock_gen i_clock_gen (.clk(clk), .reset(reset));

  blocking_cache #(
    .num_sets (num_sets)
  ) i_dut (
    .clk            (clk),
    .reset          (reset),
    .cachereq_val   (cachereq_val),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cachereq_data  (cachereq_data),
    .cachereq_rdy   (cachereq_rdy),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_type (cacheresp_type),
    .cacheresp_data (cacheresp_data),
    .cacheresp_rdy  (cacheresp_rdy),
    .memreq_val     (memreq_val),
    .memreq_type    (memreq_type),
    .memreq_addr    (memreq_addr),
    .memreq_data    (memreq_data),
    .memreq_rdy     (memreq_rdy),
    .memresp_val    (memresp_val),
    .memresp_data   (memresp_data),
    .memresp_rdy    (memresp_rdy)
  );

  cache_checker i_checker (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Memory content before any writeback
  function automatic line_t initial_line(input addr_t a);
    line_t l;
    for (int i = 0; i < words_per_line; i++) begin
      l[i*word_bits +: word_bits] = ({a[31:4], 4'h0} + addr_t'(4 * i)) ^ 32'hA5A5_0000;
    end
    return l;
  endfunction

  // ----------------------------------------------------------
  // Memory model and response-side ready
  // ----------------------------------------------------------
  initial begin : mem_model
    logic [31:0] mem_state;
    logic        pending;
    logic [1:0]  wait_cnt;
    logic        bp_now;
    line_t       resp_line;
    addr_t       key;
    memreq_rdy    = 1'b1;
    memresp_val   = 1'b0;
    memresp_data  = '0;
    cacheresp_rdy = 1'b1;
    mem_state     = lcg_next(32'd81);
    pending       = 1'b0;
    wait_cnt      = 2'd0;
    resp_line     = '0;
    forever begin
      @(posedge clk);
      bp_now = backpressure;
      if (!reset && memresp_val && memresp_rdy) pending = 1'b0;
      if (!reset && memreq_val && memreq_rdy) begin
        key = {memreq_addr[31:4], 4'h0};
        if (memreq_type == req_write) begin
          mem_lines[key]  = memreq_data;
          mem_writes++;
          last_write_addr = key;
          last_write_line = memreq_data;
          resp_line       = '0;
        end else begin
          resp_line      = mem_lines.exists(key) ? mem_lines[key] : initial_line(key);
          mem_reads++;
          last_read_addr = key;
        end
        mem_state = lcg_next(mem_state);
        wait_cnt  = mem_state[17:16];
        pending   = 1'b1;
      end else if (pending && wait_cnt != 2'd0) begin
        wait_cnt = wait_cnt - 2'd1;
      end
      mem_state = lcg_next(mem_state);
      #1;
      memresp_val   = pending && (wait_cnt == 2'd0);
      memresp_data  = (pending && wait_cnt == 2'd0) ? resp_line : '0;
      memreq_rdy    = !pending && (!bp_now || mem_state[24]);
      cacheresp_rdy = !bp_now || mem_state[27];
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Run stopped after %0d cycles without finishing", timeout_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_directed(input logic ok, input string what);
    if (!ok) begin
      $display("** Error at %0t: %s", $time, what);
      directed_errors++;
    end
  endtask

  // Called 1 ns after an edge, returns 1 ns after the response edge
  task automatic send_request(input req_type_t kind, input addr_t addr, input word_t data);
    cachereq_val  = 1'b1;
    cachereq_type = kind;
    cachereq_addr = addr;
    cachereq_data = data;
    issued++;
    @(posedge clk);
    while (!cachereq_rdy) @(posedge clk);
    #1;
    cachereq_val = 1'b0;
    @(posedge clk);
    while (!(cacheresp_val && cacheresp_rdy)) @(posedge clk);
    #1;
  endtask

  task automatic run_random(input int count, input addr_t base, input addr_t mask);
    req_type_t kind;
    addr_t     addr;
    for (int i = 0; i < count; i++) begin
      stim_state = lcg_next(stim_state);
      kind       = stim_state[31] ? req_write : req_read;
      addr       = base | ((stim_state >> 6) & mask);
      stim_state = lcg_next(stim_state);
      send_request(kind, addr, stim_state);
    end
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin : stimulus
    int    reads_before;
    int    writes_before;
    line_t expect_line;
    cachereq_val  = 1'b0;
    cachereq_type = req_read;
    cachereq_addr = '0;
    cachereq_data = '0;
    stim_state    = 32'd81;
    @(negedge reset);
    check_directed(cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy,
                   "ports not idle after reset");
    @(posedge clk);
    #1;

    // Cold read refills line 0x140, then hits
    reads_before = mem_reads;
    send_request(req_read, 32'h0000_0144, '0);
    check_directed(mem_reads == reads_before + 1 && last_read_addr == 32'h0000_0140,
                   "cold read did not fetch line 0x140 exactly once");
    reads_before  = mem_reads;
    writes_before = mem_writes;
    send_request(req_read, 32'h0000_0144, '0);
    send_request(req_write, 32'h0000_0148, 32'h1234_5678);
    send_request(req_read, 32'h0000_0148, '0);
    send_request(req_read, 32'h0000_014C, '0);
    check_directed(mem_reads == reads_before && mem_writes == writes_before,
                   "hits to a resident line reached memory");

    // Three dirty lines in set 0, the first one gets evicted
    writes_before = mem_writes;
    send_request(req_write, 32'h0000_2004, 32'hDEAD_0001);
    send_request(req_write, 32'h0000_2084, 32'hDEAD_0002);
    send_request(req_write, 32'h0000_2104, 32'hDEAD_0003);
    expect_line = initial_line(32'h0000_2000);
    expect_line[63:32] = 32'hDEAD_0001;
    check_directed(mem_writes == writes_before + 1 && last_write_addr == 32'h0000_2000
                   && last_write_line == expect_line, "dirty victim writeback wrong");
    send_request(req_read, 32'h0000_2004, '0);

    backpressure = 1'b1;
    run_random(bp_reqs, 32'h0000_3000, 32'h0000_03FC);
    backpressure = 1'b0;
    run_random(random_reqs, 32'h0000_0000, 32'h0000_0FFC);

    repeat (4) @(posedge clk);
    if (resp_count != issued) begin
      $display("Run ended with %0d responses for %0d requests", resp_count, issued);
      directed_errors++;
    end
    $display("Errors: compare %0d, protocol %0d, directed %0d", compare_errors,
             protocol_errors, directed_errors);
    if (compare_errors + protocol_errors + directed_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/cache_checker.sv
// ----------------------------------------------------------
// Port monitor for the blocking cache: shadow memory,
// response compare and handshake rules
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cachereq_val,
  input  mem_msg_pkg::req_type_t cachereq_type,
  input  cache_pkg::addr_t       cachereq_addr,
  input  cache_pkg::word_t       cachereq_data,
  input  logic                   cachereq_rdy,
  input  logic                   cacheresp_val,
  input  mem_msg_pkg::req_type_t cacheresp_type,
  input  cache_pkg::word_t       cacheresp_data,
  input  logic                   cacheresp_rdy,
  input  logic                   memreq_val,
  input  mem_msg_pkg::req_type_t memreq_type,
  input  mem_msg_pkg::mem_addr_t memreq_addr,
  input  cache_pkg::line_t       memreq_data,
  input  logic                   memreq_rdy,
  output int                     compare_errors,
  output int                     protocol_errors,
  output int                     resp_count
);
  import cache_pkg::*;
  import mem_msg_pkg::*;

  // Shadow of every word written so far, keyed by word address
  word_t     shadow [addr_t];
  req_type_t exp_type_q [$];
  word_t     exp_data_q [$];
  addr_t     exp_addr_q [$];

  addr_t     cur_addr;
  int        trans_reads;
  int        trans_writes;
  int        cycle;
  int        accept_cycle;
  logic      val_seen;
  logic      mreq_held;
  logic      resp_held;
  req_type_t held_mtype;
  addr_t     held_maddr;
  line_t     held_mdata;
  req_type_t held_rtype;
  word_t     held_rdata;

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic word_t expected_word(input addr_t a);
    addr_t wa;
    wa = {a[31:2], 2'b00};
    if (shadow.exists(wa)) return shadow[wa];
    return wa ^ 32'hA5A5_0000;
  endfunction

  function automatic line_t expected_line(input addr_t a);
    line_t l;
    for (int i = 0; i < words_per_line; i++) begin
      l[i*word_bits +: word_bits] = expected_word({a[31:4], 4'h0} + addr_t'(4 * i));
    end
    return l;
  endfunction

  always @(posedge clk) begin
    cycle++;
    if (reset) begin
      compare_errors  = 0;
      protocol_errors = 0;
      resp_count      = 0;
      mreq_held       = 1'b0;
      resp_held       = 1'b0;
      val_seen        = 1'b0;
    end else begin
      // Stalled payloads must not move
      if (mreq_held && (!memreq_val || memreq_addr != held_maddr || memreq_type != held_mtype
          || (held_mtype == req_write && memreq_data != held_mdata))) begin
        $display("** Error at %0t: memory request changed before its transfer", $time);
        protocol_errors++;
      end
      if (resp_held && (!cacheresp_val || cacheresp_type != held_rtype
          || cacheresp_data != held_rdata)) begin
        $display("** Error at %0t: response changed before its transfer", $time);
        protocol_errors++;
      end
      if (cacheresp_val && cachereq_rdy) begin
        $display("** Error at %0t: new request accepted while a response is pending", $time);
        protocol_errors++;
      end

      if (cachereq_val && cachereq_rdy) begin
        if (cachereq_type == req_write) shadow[{cachereq_addr[31:2], 2'b00}] = cachereq_data;
        exp_type_q.push_back(cachereq_type);
        exp_data_q.push_back(expected_word(cachereq_addr));
        exp_addr_q.push_back(cachereq_addr);
        cur_addr     = cachereq_addr;
        trans_reads  = 0;
        trans_writes = 0;
        accept_cycle = cycle;
        val_seen     = 1'b0;
      end

      if (memreq_val && memreq_rdy) begin
        if (memreq_type == req_write) begin
          trans_writes++;
          if (memreq_data != expected_line(memreq_addr) || memreq_addr[3:0] != 4'h0) begin
            $display("** Error at %0t: writeback to %h carries %h, expected %h", $time,
                     memreq_addr, memreq_data, expected_line(memreq_addr));
            compare_errors++;
          end
        end else begin
          trans_reads++;
          if (memreq_addr != {cur_addr[31:4], 4'h0}) begin
            $display("** Error at %0t: refill from %h for request %h", $time,
                     memreq_addr, cur_addr);
            compare_errors++;
          end
        end
      end

      // A hit answers three cycles after acceptance
      if (cacheresp_val && !val_seen) begin
        val_seen = 1'b1;
        if (trans_reads == 0 && trans_writes == 0 && cycle - accept_cycle != 3) begin
          $display("** Error at %0t: hit latency %0d cycles, expected 3", $time,
                   cycle - accept_cycle);
          protocol_errors++;
        end
      end

      if (cacheresp_val && cacheresp_rdy) begin
        resp_count++;
        if (exp_type_q.size() == 0) begin
          $display("Response at %0t arrived with no request outstanding", $time);
          protocol_errors++;
        end else begin
          if (cacheresp_type != exp_type_q[0] || (exp_type_q[0] == req_read
              && cacheresp_data != exp_data_q[0])) begin
            $display("** Error at %0t: addr %h got type %0d data %h, expected type %0d data %h",
                     $time, exp_addr_q[0], cacheresp_type, cacheresp_data, exp_type_q[0],
                     exp_data_q[0]);
            compare_errors++;
          end
          void'(exp_type_q.pop_front());
          void'(exp_data_q.pop_front());
          void'(exp_addr_q.pop_front());
        end
        if (trans_reads > 1 || trans_writes > 1 || (trans_writes == 1 && trans_reads == 0)) begin
          $display("** Error at %0t: %0d memory reads and %0d writes for one request", $time,
                   trans_reads, trans_writes);
          protocol_errors++;
        end
      end

      mreq_held  = memreq_val && !memreq_rdy;
      held_mtype = memreq_type;
      held_maddr = memreq_addr;
      held_mdata = memreq_data;
      resp_held  = cacheresp_val && !cacheresp_rdy;
      held_rtype = cacheresp_type;
      held_rdata = cacheresp_data;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// ----------------------------------------------------------
// Testbench clock of 8 ns and a reset held for two cycles
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Release lands 1 ns after an edge, like all other stimulus
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire
